//--- vlog.f
verilog/eeprom_pkg.sv
verilog/bus_event_if.sv
verilog/shift_if.sv
verilog/bus_condition_detect.sv
verilog/byte_shifter.sv
verilog/storage_array.sv
verilog/transfer_control.sv
verilog/i2c_eeprom.sv
verification/tb_i2c_eeprom.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the I2C EEPROM testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_i2c_eeprom -f vlog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_i2c_eeprom > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0

//--- verification/tb_i2c_eeprom.sv
`timescale 1ns/100ps

module tb_i2c_eeprom;
    import eeprom_pkg::*;

    localparam int          CLK_PERIOD   = 4;
    localparam int          PHASE_CYCLES = 16;
    localparam int          SWEEP_COUNT  = 40;
    localparam logic [3:0]  GOOD_CODE    = 4'b1010;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    localparam logic [31:0] LFSR_SEED    = 32'h0000_f3dc;
    // A random read is the longest transfer, 81 bus phases
    localparam int PHASES_PER_TRANSFER = 84;
    localparam int TRANSFER_COUNT      = 2 * SWEEP_COUNT + 8;
    localparam int WATCHDOG_NS         =
        (TRANSFER_COUNT * PHASES_PER_TRANSFER * PHASE_CYCLES + 4000) * CLK_PERIOD;

    logic        scl        = 1'b0;
    logic        rst_n      = 1'b0;
    logic        i2c_clk    = 1'b1;
    logic        sda_m      = 1'b1;
    logic [31:0] lfsr_state = LFSR_SEED;
    logic        sda_line;
    logic        sda_drive_low;
    byte_t       model_mem [0:2**MEM_ADDR_BITS-1];
    mem_addr_t   sweep_addr [0:SWEEP_COUNT-1];
    int          test_errors   = 0;
    int          tests_run     = 0;
    int          tests_failed  = 0;
    int          checks_failed = 0;

    // Wired-AND of master and target on the data line
    assign sda_line = sda_m & ~sda_drive_low;

    i2c_eeprom #(
        .DEVICE_CODE (GOOD_CODE),
        .SYNC_STAGES (2)
    ) UUT (
        .scl           (scl),
        .rst_n         (rst_n),
        .i2c_clk       (i2c_clk),
        .sda           (sda_line),
        .sda_drive_low (sda_drive_low)
    );

    always #(CLK_PERIOD / 2) scl = ~scl;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ LFSR_TAPS;
        else
            return state >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic compare_byte(input string name, input byte_t expected, input byte_t actual);
        if (expected !== actual)
        begin
            $display("error %s: expected %02h, actual %02h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic compare_ack(input string name, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            $display("error %s: expected ack %0b, actual ack %0b", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_acks(input string name, input logic expected, input logic [2:0] acks);
        for (int i = 0; i < 3; i++)
        begin
            compare_ack(name, expected, acks[i]);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        checks_failed += test_errors;
        if (test_errors == 0)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            $display("test %s: %0d check(s) wrong", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // One bit: low phase with data set, high phase with a mid-phase sample
    task automatic clock_bit(input logic bit_val, output logic line_seen);
        @(posedge scl);
        sda_m <= bit_val;
        repeat (PHASE_CYCLES - 1) @(posedge scl);
        i2c_clk <= 1'b1;
        repeat (PHASE_CYCLES / 2) @(posedge scl);
        @(negedge scl);
        line_seen = sda_line;
        repeat (PHASE_CYCLES / 2) @(posedge scl);
        i2c_clk <= 1'b0;
    endtask

    task automatic send_start();
        @(posedge scl);
        sda_m <= 1'b1;
        repeat (PHASE_CYCLES - 1) @(posedge scl);
        i2c_clk <= 1'b1;
        repeat (PHASE_CYCLES) @(posedge scl);
        sda_m <= 1'b0;
        repeat (PHASE_CYCLES) @(posedge scl);
        i2c_clk <= 1'b0;
    endtask

    task automatic send_stop();
        @(posedge scl);
        sda_m <= 1'b0;
        repeat (PHASE_CYCLES - 1) @(posedge scl);
        i2c_clk <= 1'b1;
        repeat (PHASE_CYCLES) @(posedge scl);
        sda_m <= 1'b1;
        repeat (PHASE_CYCLES) @(posedge scl);
    endtask

    task automatic send_byte(input byte_t value, output logic acked);
        logic line_seen;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(value[i], line_seen);
        end
        clock_bit(1'b1, line_seen);
        acked = ~line_seen;
    endtask

    task automatic receive_byte(input logic nack, output byte_t value);
        logic line_seen;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, line_seen);
            value[i] = line_seen;
        end
        clock_bit(nack, line_seen);
    endtask

    // acks holds control, address and data acknowledge, high bit first
    task automatic write_transfer(input logic [3:0] code, input mem_addr_t addr,
                                  input byte_t data, output logic [2:0] acks);
        send_start();
        send_byte({code, addr[MEM_ADDR_BITS-1:WORD_BITS], 1'b0}, acks[2]);
        send_byte(addr[WORD_BITS-1:0], acks[1]);
        send_byte(data, acks[0]);
        send_stop();
    endtask

    task automatic read_transfer(input mem_addr_t addr, output byte_t data,
                                 output logic [2:0] acks);
        send_start();
        send_byte({GOOD_CODE, addr[MEM_ADDR_BITS-1:WORD_BITS], 1'b0}, acks[2]);
        send_byte(addr[WORD_BITS-1:0], acks[1]);
        send_start();
        send_byte({GOOD_CODE, addr[MEM_ADDR_BITS-1:WORD_BITS], 1'b1}, acks[0]);
        receive_byte(1'b1, data);
        send_stop();
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        int          i;
        int          j;
        int          tmp;
        int          order [0:SWEEP_COUNT-1];
        logic [31:0] r;
        logic [2:0]  acks;
        logic [3:0]  bad_code;
        logic        line_seen;
        mem_addr_t   addr;
        byte_t       data;
        byte_t       got;

        repeat (10) @(posedge scl);
        rst_n <= 1'b1;
        repeat (PHASE_CYCLES) @(posedge scl);

        draw_bits(MEM_ADDR_BITS, r);
        addr = r[MEM_ADDR_BITS-1:0];
        draw_bits(8, r);
        data = r[7:0];
        write_transfer(GOOD_CODE, addr, data, acks);
        model_mem[addr] = data;
        check_acks("byte_write", 1'b1, acks);
        finish_test("byte_write");

        read_transfer(addr, got, acks);
        check_acks("random_read", 1'b1, acks);
        compare_byte("random_read", model_mem[addr], got);
        finish_test("random_read");

        // Index low bits pick the block so all eight get written
        for (i = 0; i < SWEEP_COUNT; i++)
        begin
            draw_bits(8, r);
            sweep_addr[i] = {i[2:0], r[7:0]};
            draw_bits(8, r);
            write_transfer(GOOD_CODE, sweep_addr[i], r[7:0], acks);
            model_mem[sweep_addr[i]] = r[7:0];
            check_acks("block_sweep", 1'b1, acks);
            order[i] = i;
        end
        for (i = SWEEP_COUNT - 1; i > 0; i--)
        begin
            draw_bits(6, r);
            j = r % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < SWEEP_COUNT; i++)
        begin
            read_transfer(sweep_addr[order[i]], got, acks);
            check_acks("block_sweep", 1'b1, acks);
            compare_byte("block_sweep", model_mem[sweep_addr[order[i]]], got);
        end
        finish_test("block_sweep");

        bad_code = GOOD_CODE;
        while (bad_code == GOOD_CODE)
        begin
            draw_bits(4, r);
            bad_code = r[3:0];
        end
        draw_bits(6, r);
        addr = sweep_addr[r % SWEEP_COUNT];
        write_transfer(bad_code, addr, ~model_mem[addr], acks);
        check_acks("wrong_code", 1'b0, acks);
        read_transfer(addr, got, acks);
        check_acks("wrong_code", 1'b1, acks);
        compare_byte("wrong_code", model_mem[addr], got);
        finish_test("wrong_code");

        // Half a data byte, then stop
        draw_bits(6, r);
        addr = sweep_addr[r % SWEEP_COUNT];
        data = ~model_mem[addr];
        send_start();
        send_byte({GOOD_CODE, addr[MEM_ADDR_BITS-1:WORD_BITS], 1'b0}, acks[2]);
        send_byte(addr[WORD_BITS-1:0], acks[1]);
        for (i = 7; i >= 4; i--)
        begin
            clock_bit(data[i], line_seen);
        end
        send_stop();
        compare_ack("stop_mid_byte", 1'b1, acks[2]);
        compare_ack("stop_mid_byte", 1'b1, acks[1]);
        read_transfer(addr, got, acks);
        check_acks("stop_mid_byte", 1'b1, acks);
        compare_byte("stop_mid_byte", model_mem[addr], got);
        draw_bits(MEM_ADDR_BITS, r);
        addr = r[MEM_ADDR_BITS-1:0];
        draw_bits(8, r);
        write_transfer(GOOD_CODE, addr, r[7:0], acks);
        model_mem[addr] = r[7:0];
        check_acks("stop_mid_byte", 1'b1, acks);
        read_transfer(addr, got, acks);
        check_acks("stop_mid_byte", 1'b1, acks);
        compare_byte("stop_mid_byte", model_mem[addr], got);
        finish_test("stop_mid_byte");

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, checks_failed);
        if (checks_failed == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- verilog/i2c_eeprom.sv
`timescale 1ns/100ps

module i2c_eeprom #(
    parameter logic [3:0] DEVICE_CODE = eeprom_pkg::DEVICE_CODE,
    parameter int          SYNC_STAGES = 2
) (
    input  logic scl,
    input  logic rst_n,
    input  logic i2c_clk,
    input  logic sda,
    output logic sda_drive_low
);
    import eeprom_pkg::*;

    logic      write_en;
    mem_addr_t mem_addr;
    byte_t     write_data;
    byte_t     read_data;

    bus_event_if ev_bus ();
    shift_if     sh_bus ();

    bus_condition_detect #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_detect (
        .scl     (scl),
        .rst_n   (rst_n),
        .i2c_clk (i2c_clk),
        .sda     (sda),
        .ev      (ev_bus.source)
    );

    byte_shifter u_shifter (
        .scl           (scl),
        .rst_n         (rst_n),
        .ev            (ev_bus.sink),
        .sh            (sh_bus.shift),
        .sda_drive_low (sda_drive_low)
    );

    transfer_control #(
        .DEVICE_CODE (DEVICE_CODE)
    ) u_control (
        .scl        (scl),
        .rst_n      (rst_n),
        .ev         (ev_bus.sink),
        .sh         (sh_bus.ctrl),
        .write_en   (write_en),
        .mem_addr   (mem_addr),
        .write_data (write_data),
        .read_data  (read_data)
    );

    storage_array u_storage (
        .scl        (scl),
        .write_en   (write_en),
        .addr       (mem_addr),
        .write_data (write_data),
        .read_data  (read_data)
    );

endmodule

//--- verilog/transfer_control.sv
`timescale 1ns/100ps

module transfer_control #(
    parameter logic [3:0] DEVICE_CODE = eeprom_pkg::DEVICE_CODE
) (
    input  logic                  scl,
    input  logic                  rst_n,
    bus_event_if.sink             ev,
    shift_if.ctrl                 sh,
    output logic                  write_en,
    output eeprom_pkg::mem_addr_t mem_addr,
    output eeprom_pkg::byte_t     write_data,
    input  eeprom_pkg::byte_t     read_data
);
    import eeprom_pkg::*;

    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_CTRL   = 3'd1;
    localparam logic [2:0] ST_ACK    = 3'd2;
    localparam logic [2:0] ST_WORD   = 3'd3;
    localparam logic [2:0] ST_WRITE  = 3'd4;
    localparam logic [2:0] ST_READ   = 3'd5;
    localparam logic [2:0] ST_MACK   = 3'd6;
    localparam logic [2:0] ST_IGNORE = 3'd7;

    logic [2:0]            state;
    logic [2:0]            after_ack;
    logic                  ack_clocked;
    logic [BLOCK_BITS-1:0] block_reg;
    logic [WORD_BITS-1:0]  word_reg;
    ctrl_byte_u            ctrl_view;

    assign ctrl_view.raw = sh.rx_byte;
    assign mem_addr      = {block_reg, word_reg};

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            state        <= ST_IDLE;
            after_ack    <= ST_IDLE;
            ack_clocked  <= 1'b0;
            block_reg    <= '0;
            word_reg     <= '0;
            write_en     <= 1'b0;
            sh.load      <= 1'b0;
            sh.clear     <= 1'b0;
            sh.drive_en  <= 1'b0;
            sh.ack_drive <= 1'b0;
        end
        else
        begin
            write_en <= 1'b0;
            sh.load  <= 1'b0;
            sh.clear <= 1'b0;
            if (ev.start || ev.stop)
            begin
                // Repeated start re-enters the control byte; stop drops a partial byte
                state        <= ev.start ? ST_CTRL : ST_IDLE;
                sh.clear     <= 1'b1;
                sh.drive_en  <= 1'b0;
                sh.ack_drive <= 1'b0;
            end
            else
            begin
                case (state)
                    ST_CTRL:
                    begin
                        if (sh.byte_done)
                        begin
                            if (ctrl_view.field.device_code == DEVICE_CODE)
                            begin
                                block_reg   <= ctrl_view.field.block;
                                after_ack   <= ctrl_view.field.read_not_write ? ST_READ : ST_WORD;
                                ack_clocked <= 1'b0;
                                state       <= ST_ACK;
                            end
                            else
                            begin
                                state <= ST_IGNORE;
                            end
                        end
                    end
                    ST_WORD:
                    begin
                        if (sh.byte_done)
                        begin
                            word_reg    <= sh.rx_byte;
                            after_ack   <= ST_WRITE;
                            ack_clocked <= 1'b0;
                            state       <= ST_ACK;
                        end
                    end
                    ST_WRITE:
                    begin
                        if (sh.byte_done)
                        begin
                            write_en    <= 1'b1;
                            after_ack   <= ST_IGNORE;
                            ack_clocked <= 1'b0;
                            state       <= ST_ACK;
                        end
                    end
                    ST_ACK:
                    begin
                        if (ev.clk_rise)
                        begin
                            ack_clocked <= 1'b1;
                            sh.clear    <= 1'b1;
                        end
                        else if (ev.clk_fall && !ack_clocked)
                        begin
                            sh.ack_drive <= 1'b1;
                        end
                        else if (ev.clk_fall)
                        begin
                            sh.ack_drive <= 1'b0;
                            state        <= after_ack;
                            if (after_ack == ST_READ)
                            begin
                                sh.load     <= 1'b1;
                                sh.drive_en <= 1'b1;
                            end
                        end
                    end
                    ST_READ:
                    begin
                        if (sh.byte_done)
                        begin
                            state <= ST_MACK;
                        end
                    end
                    ST_MACK:
                    begin
                        // Release the line for the master's NACK
                        if (ev.clk_fall)
                        begin
                            sh.drive_en <= 1'b0;
                        end
                        else if (ev.clk_rise)
                        begin
                            sh.clear <= 1'b1;
                            state    <= ST_IGNORE;
                        end
                    end
                    default:
                    begin
                        state <= state;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (state == ST_ACK && ev.clk_fall)
        begin
            sh.load_byte <= read_data;
        end
        if (state == ST_WRITE && sh.byte_done)
        begin
            write_data <= sh.rx_byte;
        end
    end

endmodule

//--- verilog/storage_array.sv
`timescale 1ns/100ps

module storage_array (
    input  logic                 scl,
    input  logic                 write_en,
    input  eeprom_pkg::mem_addr_t addr,
    input  eeprom_pkg::byte_t     write_data,
    output eeprom_pkg::byte_t     read_data
);
    import eeprom_pkg::*;

    localparam int DEPTH = 2 ** MEM_ADDR_BITS;

    byte_t mem [0:DEPTH-1];

    always_ff @(posedge scl)
    begin
        if (write_en)
        begin
            mem[addr] <= write_data;
        end
        read_data <= mem[addr];
    end

endmodule

//--- verilog/byte_shifter.sv
`timescale 1ns/100ps

module byte_shifter (
    input  logic       scl,
    input  logic       rst_n,
    bus_event_if.sink  ev,
    shift_if.shift     sh,
    output logic       sda_drive_low
);
    import eeprom_pkg::*;

    logic [2:0] bit_cnt;
    byte_t      rx_reg;
    byte_t      tx_reg;
    byte_t      tx_next;
    logic       fall_d;

    assign sh.byte_done = ev.clk_rise && (bit_cnt == 3'd7);
    assign sh.rx_byte   = {rx_reg[6:0], ev.sda_level};

    // MSB of tx_reg is the bit on the bus
    assign tx_next = sh.load ? sh.load_byte : {tx_reg[6:0], 1'b1};

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            bit_cnt <= 3'd0;
        end
        else if (sh.clear)
        begin
            bit_cnt <= 3'd0;
        end
        else if (ev.clk_rise)
        begin
            bit_cnt <= bit_cnt + 3'd1;
        end
    end

    always_ff @(posedge scl)
    begin
        if (ev.clk_rise)
        begin
            rx_reg <= sh.rx_byte;
        end
        if (fall_d)
        begin
            tx_reg <= tx_next;
        end
    end

    // Output moves one cycle after the fall strobe, once control has reacted
    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            fall_d        <= 1'b0;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            fall_d <= ev.clk_fall;
            if (ev.stop)
            begin
                sda_drive_low <= 1'b0;
            end
            else if (fall_d)
            begin
                sda_drive_low <= sh.ack_drive | (sh.drive_en & ~tx_next[7]);
            end
        end
    end

endmodule

//--- verilog/bus_condition_detect.sv
`timescale 1ns/100ps

module bus_condition_detect #(
    parameter int SYNC_STAGES = 2
) (
    input  logic        scl,
    input  logic        rst_n,
    input  logic        i2c_clk,
    input  logic        sda,
    bus_event_if.source ev
);

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] sda_sync;
    logic                   clk_prev;
    logic                   sda_prev;
    logic                   clk_now;
    logic                   sda_now;

    assign clk_now = clk_sync[SYNC_STAGES-1];
    assign sda_now = sda_sync[SYNC_STAGES-1];

    // Both lines idle high, so reset to ones to avoid false events
    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            clk_sync <= '1;
            sda_sync <= '1;
            clk_prev <= 1'b1;
            sda_prev <= 1'b1;
        end
        else
        begin
            clk_sync[0] <= i2c_clk;
            sda_sync[0] <= sda;
            for (int i = 1; i < SYNC_STAGES; i++)
            begin
                clk_sync[i] <= clk_sync[i-1];
                sda_sync[i] <= sda_sync[i-1];
            end
            clk_prev <= clk_now;
            sda_prev <= sda_now;
        end
    end

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            ev.clk_rise  <= 1'b0;
            ev.clk_fall  <= 1'b0;
            ev.start     <= 1'b0;
            ev.stop      <= 1'b0;
            ev.sda_level <= 1'b1;
        end
        else
        begin
            ev.clk_rise  <= clk_now & ~clk_prev;
            ev.clk_fall  <= ~clk_now & clk_prev;
            // Data moving while the clock is high
            ev.start     <= clk_now & clk_prev & sda_prev & ~sda_now;
            ev.stop      <= clk_now & clk_prev & ~sda_prev & sda_now;
            ev.sda_level <= sda_now;
        end
    end

endmodule

//--- verilog/shift_if.sv
`timescale 1ns/100ps

interface shift_if;
    import eeprom_pkg::*;

    logic  load;
    byte_t load_byte;
    logic  drive_en;
    logic  ack_drive;
    logic  clear;
    logic  byte_done;
    byte_t rx_byte;

    modport ctrl (
        output load, load_byte, drive_en, ack_drive, clear,
        input  byte_done, rx_byte
    );

    modport shift (
        input  load, load_byte, drive_en, ack_drive, clear,
        output byte_done, rx_byte
    );

endinterface

//--- verilog/bus_event_if.sv
`timescale 1ns/100ps

interface bus_event_if;

    logic clk_rise;
    logic clk_fall;
    logic start;
    logic stop;
    logic sda_level;

    modport source (
        output clk_rise, clk_fall, start, stop, sda_level
    );

    modport sink (
        input clk_rise, clk_fall, start, stop, sda_level
    );

endinterface

//--- verilog/eeprom_pkg.sv
package eeprom_pkg;

    // Upper nibble of a control byte addressed to this part
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    localparam int BLOCK_BITS    = 3;
    localparam int WORD_BITS     = 8;
    localparam int MEM_ADDR_BITS = BLOCK_BITS + WORD_BITS;

    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;
    typedef logic [7:0]               byte_t;

    typedef struct packed {
        logic [3:0]            device_code;
        logic [BLOCK_BITS-1:0] block;
        logic                  read_not_write;
    } ctrl_fields_t;

    // Raw view as shifted in, field view for decoding
    typedef union packed {
        byte_t        raw;
        ctrl_fields_t field;
    } ctrl_byte_u;

endpackage
